/* source/m92_settings.svh */
// M92 CPU memory side settings
// Bus widths, ROM cache geometry and the CPU memory map
`ifndef M92_SETTINGS_SVH
`define M92_SETTINGS_SVH

// Bus and storage widths
`define M92_CPU_ADDR_W        20
`define M92_SDR_ADDR_W        25
`define M92_CACHE_LINES_LOG2  5
`define M92_RAM_WORDS_LOG2    15

// Plain ROM lies below M92_ROM_END
`define M92_ROM_END           20'hA0000

// Window limits are inclusive
`define M92_BANK_BASE         20'hA0000
`define M92_BANK_END          20'hAFFFF
`define M92_BANK_ROM_BASE     25'h0100000
`define M92_RAM_BASE          20'hE0000
`define M92_RAM_END           20'hEFFFF

`endif

/* source/m92_bus_pkg.sv */
// M92 CPU bus package
// Request, response and decoded request types shared by the pipeline stages
`default_nettype none
`include "m92_settings.svh"

package m92_bus_pkg;

    typedef enum logic [1:0] {
        mem_read  = 2'd0,
        mem_write = 2'd1,
        io_read   = 2'd2,
        io_write  = 2'd3
    } req_kind_e;

    typedef enum logic [1:0] {
        rgn_rom  = 2'd0,
        rgn_ram  = 2'd1,
        rgn_io   = 2'd2,
        rgn_none = 2'd3
    } region_e;

    typedef struct packed {
        req_kind_e                   kind;
        logic [`M92_CPU_ADDR_W-1:0]  addr;
        logic [15:0]                 wdata;
        logic [1:0]                  byte_en;
    } cpu_req_t;

    typedef struct packed {
        logic [15:0] rdata;
    } cpu_rsp_t;

    // Stage 1 output with write data already in its byte lane
    typedef struct packed {
        region_e                         region;
        req_kind_e                       kind;
        logic [`M92_SDR_ADDR_W-1:0]      rom_addr;
        logic [`M92_RAM_WORDS_LOG2-1:0]  ram_index;
        logic                            lane_odd;
        logic [15:0]                     wdata;
        logic [1:0]                      byte_en;
        logic [7:0]                      io_addr;
    } dec_req_t;

endpackage

`default_nettype wire

/* source/m92_io_pkg.sv */
// M92 I/O package
// Port numbers and the board input bundle
`default_nettype none

package m92_io_pkg;

    typedef enum logic [7:0] {
        port_p1_p2 = 8'h00,
        port_flags = 8'h02,
        port_dip   = 8'h04,
        port_p3_p4 = 8'h06,
        port_bank  = 8'h20
    } io_port_e;

    // Bits 3..0 are directions and bits 9..4 are buttons, all active high
    typedef struct packed {
        logic [9:0] p1;
        logic [9:0] p2;
        logic [9:0] p3;
        logic [9:0] p4;
        logic [3:0] coin;
        logic [3:0] start;
    } player_in_t;

endpackage

`default_nettype wire

/* source/m92_addr_decode.sv */
// M92 address decode, pipeline stage 1
// Registers an accepted CPU request and classifies it by region
`timescale 1ns/10ps
`default_nettype none
`include "m92_settings.svh"

module m92_addr_decode (
    input  wire logic                   clk_sys,
    input  wire logic                   reset_n,
    input  wire logic                   stall,
    input  wire logic                   req_valid,
    input  wire m92_bus_pkg::cpu_req_t  req,
    input  wire logic [3:0]             bank,
    output logic                        dec_valid,
    output m92_bus_pkg::dec_req_t       dec
);

    m92_bus_pkg::dec_req_t next_dec;
    logic [3:0]            bank_eff;
    logic                  in_bank;
    logic                  in_ram;

    // A bank write still sitting here must reach the request right behind it
    assign bank_eff = (dec_valid && dec.kind == m92_bus_pkg::io_write &&
                       dec.io_addr == m92_io_pkg::port_bank) ? dec.wdata[3:0] : bank;

    assign in_bank = (req.addr >= `M92_BANK_BASE) && (req.addr <= `M92_BANK_END);
    assign in_ram  = (req.addr >= `M92_RAM_BASE) && (req.addr <= `M92_RAM_END);

    always_comb begin
        next_dec.kind      = req.kind;
        next_dec.rom_addr  = `M92_SDR_ADDR_W'(req.addr);
        next_dec.ram_index = req.addr[`M92_RAM_WORDS_LOG2:1];
        next_dec.lane_odd  = req.addr[0];
        next_dec.io_addr   = req.addr[7:0];
        // Odd byte moves up into the high lane
        next_dec.wdata     = req.addr[0] ? {req.wdata[7:0], 8'h00} : req.wdata;
        next_dec.byte_en   = req.addr[0] ? {req.byte_en[0], 1'b0} : req.byte_en;

        if (req.kind == m92_bus_pkg::io_read || req.kind == m92_bus_pkg::io_write) begin
            next_dec.region = m92_bus_pkg::rgn_io;
        end else if (req.addr < `M92_ROM_END) begin
            next_dec.region = m92_bus_pkg::rgn_rom;
        end else if (in_bank) begin
            next_dec.region   = m92_bus_pkg::rgn_rom;
            next_dec.rom_addr = `M92_BANK_ROM_BASE +
                                `M92_SDR_ADDR_W'({bank_eff, req.addr[15:0]});
        end else if (in_ram) begin
            next_dec.region = m92_bus_pkg::rgn_ram;
        end else begin
            next_dec.region = m92_bus_pkg::rgn_none;
        end
    end

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= req_valid;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!stall) begin
            dec <= next_dec;
        end
    end

    a_io_region: assert property (@(posedge clk_sys) disable iff (!reset_n)
        dec_valid |-> ((dec.region == m92_bus_pkg::rgn_io) ==
                       (dec.kind == m92_bus_pkg::io_read || dec.kind == m92_bus_pkg::io_write)));

endmodule

`default_nettype wire

/* source/m92_rom_cache.sv */
// M92 ROM cache, pipeline stage 2 ROM path
// Direct mapped line cache filled from SDRAM in 64-bit bursts
`timescale 1ns/10ps
`default_nettype none
`include "m92_settings.svh"

module m92_rom_cache (
    input  wire logic                       clk_sys,
    input  wire logic                       reset_n,
    input  wire logic                       dec_valid,
    input  wire m92_bus_pkg::dec_req_t      dec,
    output logic                            stall,
    output logic [15:0]                     rom_word,
    output logic                            sdr_req,
    output logic [`M92_SDR_ADDR_W-1:0]      sdr_addr,
    input  wire logic                       sdr_rdy,
    input  wire logic [63:0]                sdr_data
);

    localparam int LINES_LOG2 = `M92_CACHE_LINES_LOG2;
    localparam int LINES      = 2 ** LINES_LOG2;
    localparam int TAG_LSB    = LINES_LOG2 + 3;
    localparam int TAG_W      = `M92_SDR_ADDR_W - TAG_LSB;

    typedef enum logic {
        cache_idle,
        cache_fill
    } cache_state_e;

    cache_state_e          state;
    logic [TAG_W-1:0]      tag_mem [LINES];
    logic [LINES-1:0]      tag_valid;
    logic [15:0]           data_mem [LINES*4];
    logic [LINES_LOG2-1:0] line;
    logic [TAG_W-1:0]      tag;
    logic                  rom_read;
    logic                  hit;

    // ========================================================================
    // Lookup
    // ========================================================================

    assign line     = dec.rom_addr[TAG_LSB-1:3];
    assign tag      = dec.rom_addr[`M92_SDR_ADDR_W-1:TAG_LSB];
    assign rom_read = dec_valid && dec.region == m92_bus_pkg::rgn_rom &&
                      dec.kind == m92_bus_pkg::mem_read;
    assign hit      = tag_valid[line] && (tag_mem[line] == tag);

    // Writes to ROM never fill
    assign sdr_req  = (state == cache_idle) && rom_read && !hit;
    assign sdr_addr = {dec.rom_addr[`M92_SDR_ADDR_W-1:3], 3'b000};

    // The stage 1 register stays frozen, so dec still names the line being filled
    assign stall    = sdr_req || (state == cache_fill);

    // ========================================================================
    // Fill state machine
    // ========================================================================

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            state     <= cache_idle;
            tag_valid <= '0;
        end else begin
            case (state)
                cache_idle: begin
                    if (sdr_req) begin
                        state           <= cache_fill;
                        tag_valid[line] <= 1'b1;
                    end
                end
                cache_fill: begin
                    if (sdr_rdy) begin
                        state <= cache_idle;
                    end
                end
                default: begin
                    state <= cache_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (sdr_req) begin
            tag_mem[line] <= tag;
        end
        // Word 0 sits in the low 16 bits of the burst
        if (state == cache_fill && sdr_rdy) begin
            for (int w = 0; w < 4; w++) begin
                data_mem[{line, 2'(w)}] <= sdr_data[w*16 +: 16];
            end
        end
        if (!stall) begin
            rom_word <= data_mem[dec.rom_addr[TAG_LSB-1:1]];
        end
    end

    a_rdy_in_fill: assert property (@(posedge clk_sys) disable iff (!reset_n)
        sdr_rdy |-> state == cache_fill);

    a_no_req_in_fill: assert property (@(posedge clk_sys) disable iff (!reset_n)
        state == cache_fill |-> !sdr_req);

endmodule

`default_nettype wire

/* source/m92_io_ports.sv */
// M92 I/O ports
// Switch read multiplexer plus the system flag and bank select latches
`timescale 1ns/10ps
`default_nettype none

module m92_io_ports (
    input  wire logic                    clk_sys,
    input  wire logic                    reset_n,
    input  wire logic                    dec_valid,
    input  wire m92_bus_pkg::dec_req_t   dec,
    input  wire m92_io_pkg::player_in_t  players,
    input  wire logic [23:0]             dip_sw,
    output logic [7:0]                   io_byte,
    output logic [3:0]                   bank,
    output logic [7:0]                   sys_flags
);

    logic [7:0]  sw_p1;
    logic [7:0]  sw_p2;
    logic [7:0]  sw_p3;
    logic [7:0]  sw_p4;
    logic [15:0] flags;
    logic [15:0] port_word;
    logic        io_wr;

    // Buttons 4 and 5 on top, directions in the low nibble
    assign sw_p1 = {players.p1[4], players.p1[5], 2'b00, players.p1[3:0]};
    assign sw_p2 = {players.p2[4], players.p2[5], 2'b00, players.p2[3:0]};

    // Players 3 and 4 carry their own coin and start
    assign sw_p3 = {players.p3[4], players.p3[5], players.coin[2], players.start[2],
                    players.p3[3:0]};
    assign sw_p4 = {players.p4[4], players.p4[5], players.coin[3], players.start[3],
                    players.p4[3:0]};

    // DMA and sound status are not built here and read as 1
    assign flags = {~dip_sw[23:16], 4'b1111, ~players.coin[1:0], ~players.start[1:0]};

    always_comb begin
        case ({dec.io_addr[7:1], 1'b0})
            m92_io_pkg::port_p1_p2: port_word = {~sw_p2, ~sw_p1};
            m92_io_pkg::port_flags: port_word = flags;
            m92_io_pkg::port_dip:   port_word = ~dip_sw[15:0];
            m92_io_pkg::port_p3_p4: port_word = {~sw_p4, ~sw_p3};
            default:                port_word = 16'hFFFF;
        endcase
    end

    // Odd port address picks the high byte
    assign io_byte = dec.io_addr[0] ? port_word[15:8] : port_word[7:0];

    assign io_wr = dec_valid && dec.kind == m92_bus_pkg::io_write;

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            sys_flags <= 8'h00;
            bank      <= 4'h0;
        end else begin
            if (io_wr && dec.io_addr == m92_io_pkg::port_flags) begin
                sys_flags <= dec.wdata[7:0];
            end
            if (io_wr && dec.io_addr == m92_io_pkg::port_bank) begin
                bank <= dec.wdata[3:0];
            end
        end
    end

endmodule

`default_nettype wire

/* source/m92_read_return.sv */
// M92 work RAM and read return
// Stage 2 RAM access, stage 3 data select, lane shuffle and response register
`timescale 1ns/10ps
`default_nettype none
`include "m92_settings.svh"

module m92_read_return (
    input  wire logic                   clk_sys,
    input  wire logic                   reset_n,
    input  wire logic                   stall,
    input  wire logic                   dec_valid,
    input  wire m92_bus_pkg::dec_req_t  dec,
    input  wire logic [15:0]            rom_word,
    input  wire logic [7:0]             io_byte,
    output logic                        rsp_valid,
    output m92_bus_pkg::cpu_rsp_t       rsp
);

    localparam int RAM_WORDS = 2 ** `M92_RAM_WORDS_LOG2;

    logic [1:0][7:0]        ram [RAM_WORDS];
    logic [15:0]            ram_q;
    logic                   ram_wr;
    logic                   s2_valid;
    m92_bus_pkg::region_e   s2_region;
    m92_bus_pkg::req_kind_e s2_kind;
    logic                   s2_odd;
    logic [7:0]             s2_io_byte;
    logic [15:0]            sel_data;

    // ========================================================================
    // Stage 2
    // ========================================================================

    assign ram_wr = dec_valid && !stall && dec.region == m92_bus_pkg::rgn_ram &&
                    dec.kind == m92_bus_pkg::mem_write;

    always_ff @(posedge clk_sys) begin
        if (ram_wr) begin
            for (int b = 0; b < 2; b++) begin
                if (dec.byte_en[b]) begin
                    ram[dec.ram_index][b] <= dec.wdata[b*8 +: 8];
                end
            end
        end
        if (!stall) begin
            ram_q      <= ram[dec.ram_index];
            s2_region  <= dec.region;
            s2_kind    <= dec.kind;
            s2_odd     <= dec.lane_odd;
            s2_io_byte <= io_byte;
        end
    end

    // ========================================================================
    // Stage 3
    // ========================================================================

    always_comb begin
        logic [15:0] raw;
        case (s2_region)
            m92_bus_pkg::rgn_rom: raw = rom_word;
            m92_bus_pkg::rgn_ram: raw = ram_q;
            m92_bus_pkg::rgn_io:  raw = {8'hFF, s2_io_byte};
            default:              raw = 16'hFFFF;
        endcase

        if (s2_kind == m92_bus_pkg::mem_write || s2_kind == m92_bus_pkg::io_write) begin
            sel_data = 16'hFFFF;
        end else if (s2_odd && (s2_region == m92_bus_pkg::rgn_rom ||
                                s2_region == m92_bus_pkg::rgn_ram)) begin
            sel_data = {8'h00, raw[15:8]};
        end else begin
            sel_data = raw;
        end
    end

    // A stalled stage 2 entry must not be answered twice
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            s2_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= s2_valid && !stall;
            if (!stall) begin
                s2_valid <= dec_valid;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!stall) begin
            rsp.rdata <= sel_data;
        end
    end

endmodule

`default_nettype wire

/* source/m92_cpu_mem.sv */
// M92 main CPU memory and I/O side
// Three stage request pipeline with ROM cache, work RAM and I/O ports
`timescale 1ns/10ps
`default_nettype none
`include "m92_settings.svh"

module m92_cpu_mem (
    input  wire logic                     clk_sys,
    input  wire logic                     reset_n,
    input  wire logic                     req_valid,
    output logic                          req_ready,
    input  wire m92_bus_pkg::cpu_req_t    req,
    output logic                          rsp_valid,
    output m92_bus_pkg::cpu_rsp_t         rsp,
    output logic                          sdr_req,
    output logic [`M92_SDR_ADDR_W-1:0]    sdr_addr,
    input  wire logic                     sdr_rdy,
    input  wire logic [63:0]              sdr_data,
    input  wire m92_io_pkg::player_in_t   players,
    input  wire logic [23:0]              dip_sw,
    output logic [7:0]                    sys_flags
);

    logic                  stall;
    logic                  dec_valid;
    m92_bus_pkg::dec_req_t dec;
    logic [15:0]           rom_word;
    logic [7:0]            io_byte;
    logic [3:0]            bank;

    // Only a cache fill holds the pipeline
    assign req_ready = !stall;

    m92_addr_decode u_decode (
        .clk_sys   (clk_sys),
        .reset_n   (reset_n),
        .stall     (stall),
        .req_valid (req_valid),
        .req       (req),
        .bank      (bank),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    m92_rom_cache u_cache (
        .clk_sys   (clk_sys),
        .reset_n   (reset_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .stall     (stall),
        .rom_word  (rom_word),
        .sdr_req   (sdr_req),
        .sdr_addr  (sdr_addr),
        .sdr_rdy   (sdr_rdy),
        .sdr_data  (sdr_data)
    );

    m92_io_ports u_io (
        .clk_sys   (clk_sys),
        .reset_n   (reset_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .players   (players),
        .dip_sw    (dip_sw),
        .io_byte   (io_byte),
        .bank      (bank),
        .sys_flags (sys_flags)
    );

    m92_read_return u_return (
        .clk_sys   (clk_sys),
        .reset_n   (reset_n),
        .stall     (stall),
        .dec_valid (dec_valid),
        .dec       (dec),
        .rom_word  (rom_word),
        .io_byte   (io_byte),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

/* dv/m92_ref_model.svh */
// M92 CPU memory side reference model
// Predicts responses, tracks RAM, latches and cache tags in request order
`ifndef M92_REF_MODEL_SVH
`define M92_REF_MODEL_SVH

logic [15:0] model_ram [int];
logic [3:0]  model_bank = 4'h0;
logic [7:0]  model_flags = 8'h00;
logic [16:0] model_tag [32];
logic [31:0] model_tag_valid = '0;
logic [24:0] fill_q [$];
int          miss_count = 0;

// SDRAM contents rule for a word-aligned byte address
function automatic logic [15:0] rom_word_at(input logic [24:0] a);
    return a[16:1] ^ 16'h5A3C;
endfunction

function automatic logic [15:0] io_port_word(input logic [7:0] port);
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;
    logic [7:0] b4;
    b1 = ~{players.p1[4], players.p1[5], 2'b00, players.p1[3:0]};
    b2 = ~{players.p2[4], players.p2[5], 2'b00, players.p2[3:0]};
    b3 = ~{players.p3[4], players.p3[5], players.coin[2], players.start[2], players.p3[3:0]};
    b4 = ~{players.p4[4], players.p4[5], players.coin[3], players.start[3], players.p4[3:0]};
    case (port)
        8'h00: return {b2, b1};
        8'h02: return {~dip_sw[23:16], 4'hF, ~players.coin[1:0], ~players.start[1:0]};
        8'h04: return ~dip_sw[15:0];
        8'h06: return {b4, b3};
        default: return 16'hFFFF;
    endcase
endfunction

function automatic logic [15:0] predict_response(input m92_bus_pkg::cpu_req_t r);
    logic [24:0] ra;
    logic [15:0] w;
    logic [15:0] pw;
    int          idx;
    if (r.kind == m92_bus_pkg::io_write) begin
        if (r.addr[7:0] == 8'h02) model_flags = r.wdata[7:0];
        if (r.addr[7:0] == 8'h20) model_bank = r.wdata[3:0];
        return 16'hFFFF;
    end
    if (r.kind == m92_bus_pkg::io_read) begin
        pw = io_port_word({r.addr[7:1], 1'b0});
        return {8'hFF, r.addr[0] ? pw[15:8] : pw[7:0]};
    end
    if (r.addr < 20'hA0000 || r.addr <= 20'hAFFFF) begin
        ra = (r.addr < 20'hA0000) ? 25'(r.addr) : 25'h100000 + 25'({model_bank, r.addr[15:0]});
        if (r.kind == m92_bus_pkg::mem_write) return 16'hFFFF;
        // Tag miss means one line fill
        if (!(model_tag_valid[ra[7:3]] && model_tag[ra[7:3]] == ra[24:8])) begin
            miss_count++;
            fill_q.push_back({ra[24:3], 3'b000});
            model_tag[ra[7:3]] = ra[24:8];
            model_tag_valid[ra[7:3]] = 1'b1;
        end
        w = rom_word_at({ra[24:1], 1'b0});
        return r.addr[0] ? {8'h00, w[15:8]} : w;
    end
    if (r.addr >= 20'hE0000 && r.addr <= 20'hEFFFF) begin
        idx = int'(r.addr[15:1]);
        w = model_ram.exists(idx) ? model_ram[idx] : 16'h0000;
        if (r.kind == m92_bus_pkg::mem_write) begin
            if (r.addr[0] && r.byte_en[0]) w[15:8] = r.wdata[7:0];
            if (!r.addr[0] && r.byte_en[0]) w[7:0] = r.wdata[7:0];
            if (!r.addr[0] && r.byte_en[1]) w[15:8] = r.wdata[15:8];
            model_ram[idx] = w;
            return 16'hFFFF;
        end
        return r.addr[0] ? {8'h00, w[15:8]} : w;
    end
    return 16'hFFFF;
endfunction

`endif

/* dv/tb_m92_cpu_mem.sv */
// M92 CPU memory side testbench
// Random CPU requests against a reference model, with an SDRAM fill responder
`timescale 1ns/10ps
`default_nettype none
`include "m92_settings.svh"

module tb_m92_cpu_mem;

    logic                         clk_sys;
    logic                         reset_n;
    logic                         req_valid;
    logic                         req_ready;
    m92_bus_pkg::cpu_req_t        req;
    logic                         rsp_valid;
    m92_bus_pkg::cpu_rsp_t        rsp;
    logic                         sdr_req;
    logic [`M92_SDR_ADDR_W-1:0]   sdr_addr;
    logic                         sdr_rdy;
    logic [63:0]                  sdr_data;
    m92_io_pkg::player_in_t       players;
    logic [23:0]                  dip_sw;
    logic [7:0]                   sys_flags;

    logic [31:0] rng_state = 32'h50c0_cf02;
    logic [15:0] exp_q [$];
    time         accept_q [$];
    time         last_stall_t = 0;
    int          sdr_count = 0;

    `include "m92_ref_model.svh"

    m92_cpu_mem UUT (
        .clk_sys   (clk_sys),
        .reset_n   (reset_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .sdr_req   (sdr_req),
        .sdr_addr  (sdr_addr),
        .sdr_rdy   (sdr_rdy),
        .sdr_data  (sdr_data),
        .players   (players),
        .dip_sw    (dip_sw),
        .sys_flags (sys_flags)
    );

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================

    task automatic make_request(output m92_bus_pkg::cpu_req_t r, output logic is_flags);
        logic [31:0] x;
        logic [31:0] y;
        logic [19:0] rom_off;
        x = next_rand();
        y = next_rand();
        rom_off = {4'h0, y[2:0], 13'h0} | {15'h0, y[4:3], 3'b000} | {17'h0, y[7:5]};
        is_flags = 1'b0;
        r.kind = m92_bus_pkg::mem_read;
        r.wdata = y[31:16];
        r.byte_en = 2'b11;
        if (x[3:0] <= 4'd5) begin
            r.addr = 20'hE0000 | {5'h0, y[5:4], 8'h00, y[3:0], 1'b0} | {19'h0, y[9]};
            if (y[8]) r.kind = m92_bus_pkg::mem_write;
            if (y[9]) r.byte_en = 2'b01;
            else if (y[11:10] != 2'b00) r.byte_en = y[11:10];
        end else if (x[3:0] <= 4'd8) begin
            r.addr = rom_off;
            if (y[10:8] == 3'd0) r.kind = m92_bus_pkg::mem_write;
        end else if (x[3:0] <= 4'd10) begin
            r.addr = 20'hA0000 | rom_off;
        end else if (x[3:0] == 4'd11) begin
            r.kind = m92_bus_pkg::io_write;
            r.addr = 20'h00020;
            r.wdata = {14'h0, y[1:0]};
        end else if (x[3:0] <= 4'd13) begin
            r.kind = m92_bus_pkg::io_read;
            r.addr = y[8] ? {17'h0, y[2:0]} : {15'h0, y[4:0]};
        end else if (x[3:0] == 4'd14) begin
            r.kind = m92_bus_pkg::io_write;
            r.addr = 20'h00002;
            is_flags = 1'b1;
        end else begin
            r.addr = (y[9] ? 20'hB0000 : 20'hF0000) | {4'h0, y[31:16]};
            if (y[8]) r.kind = m92_bus_pkg::mem_write;
        end
    endtask

    // Starts on a falling edge and returns on the falling edge after acceptance
    task automatic drive_request(input m92_bus_pkg::cpu_req_t r);
        logic accepted;
        accepted = 1'b0;
        req_valid = 1'b1;
        req = r;
        while (!accepted) begin
            @(posedge clk_sys);
            accepted = req_ready;
        end
        exp_q.push_back(predict_response(r));
        accept_q.push_back($time);
        @(negedge clk_sys);
        req_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(posedge clk_sys);
        @(negedge clk_sys);
    endtask

    task automatic randomize_inputs();
        logic [31:0] a;
        logic [31:0] b;
        a = next_rand();
        b = next_rand();
        players = {a, b[15:0]};
        dip_sw = 24'(next_rand());
    endtask

    // ========================================================================
    // Response and SDRAM monitors
    // ========================================================================

    always @(posedge clk_sys) begin
        if (reset_n) begin
            if (!req_ready) last_stall_t = $time;
            if (rsp_valid) begin
                if (exp_q.size() == 0) fail_run("response arrived with no request pending");
                check_value("rsp.rdata", rsp.rdata, exp_q.pop_front());
                // Fixed latency only when no fill held the pipeline
                if (last_stall_t < accept_q[0]) begin
                    check_value("rsp latency cycles", 32'(($time - accept_q[0]) / 20), 3);
                end
                void'(accept_q.pop_front());
            end
        end
    end

    initial begin
        logic [24:0] line_addr;
        int          delay;
        forever begin
            @(posedge clk_sys);
            if (reset_n && sdr_req) begin
                if (fill_q.size() == 0) fail_run("SDRAM fill requested with no expected miss");
                sdr_count++;
                line_addr = sdr_addr;
                check_value("sdr_addr", 32'(sdr_addr), 32'(fill_q.pop_front()));
                delay = 2 + int'(next_rand() % 8);
                repeat (delay) @(negedge clk_sys);
                for (int w = 0; w < 4; w++) begin
                    sdr_data[w*16 +: 16] = rom_word_at(line_addr + 25'(2 * w));
                end
                sdr_rdy = 1'b1;
                @(negedge clk_sys);
                sdr_rdy = 1'b0;
            end
        end
    end

    initial begin
        #(600 * 20 * 20);
        $display("watchdog expired before the requests completed");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        m92_bus_pkg::cpu_req_t r;
        logic                  is_flags;
        int                    gap;
        reset_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        sdr_rdy = 1'b0;
        sdr_data = '0;
        players = '0;
        dip_sw = '0;
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        reset_n = 1'b1;
        randomize_inputs();

        // Fill every RAM word that later reads can touch
        for (int i = 0; i < 64; i++) begin
            r.kind = m92_bus_pkg::mem_write;
            r.addr = 20'hE0000 | {5'h0, 2'(i >> 4), 8'h00, 4'(i), 1'b0};
            r.wdata = 16'(next_rand());
            r.byte_en = 2'b11;
            drive_request(r);
        end

        for (int n = 0; n < 536; n++) begin
            make_request(r, is_flags);
            drive_request(r);
            if (is_flags) begin
                wait_drained();
                check_value("sys_flags", sys_flags, model_flags);
            end
            if (n % 50 == 49) begin
                wait_drained();
                randomize_inputs();
            end
            gap = int'(next_rand() % 4);
            repeat (gap) @(negedge clk_sys);
        end

        wait_drained();
        repeat (5) @(posedge clk_sys);
        check_value("sdr_req count", sdr_count, miss_count);
        check_value("pending fills", fill_q.size(), 0);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+source
+incdir+dv
source/m92_bus_pkg.sv
source/m92_io_pkg.sv
source/m92_addr_decode.sv
source/m92_rom_cache.sv
source/m92_io_ports.sv
source/m92_read_return.sv
source/m92_cpu_mem.sv
dv/tb_m92_cpu_mem.sv

/* Bender.yml */
package:
  name: m92_cpu_mem

sources:
  - include_dirs:
      - source
    files:
      - source/m92_bus_pkg.sv
      - source/m92_io_pkg.sv
      - source/m92_addr_decode.sv
      - source/m92_rom_cache.sv
      - source/m92_io_ports.sv
      - source/m92_read_return.sv
      - source/m92_cpu_mem.sv
  - target: test
    include_dirs:
      - source
      - dv
    files:
      - dv/tb_m92_cpu_mem.sv
